// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 8;
    localparam int REG_SEL_W = 2;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Opcode field, upper nibble of the first byte
    localparam logic [3:0] OP_MOV_RR  = 4'b0000;
    localparam logic [3:0] OP_MOV_IMM = 4'b0001;
    localparam logic [3:0] OP_JMP_GRP = 4'b0101;
    localparam logic [3:0] OP_AND     = 4'b1000;
    localparam logic [3:0] OP_OR      = 4'b1001;
    localparam logic [3:0] OP_XOR     = 4'b1010;
    localparam logic [3:0] OP_NOT     = 4'b1011;
    localparam logic [3:0] OP_ADD     = 4'b1100;
    localparam logic [3:0] OP_SUB     = 4'b1101;
    localparam logic [3:0] OP_INC     = 4'b1110;
    localparam logic [3:0] OP_DEC     = 4'b1111;

    localparam logic [1:0] COND_ALWAYS = 2'b00;
    localparam logic [1:0] COND_Z      = 2'b01;
    localparam logic [1:0] COND_NZ     = 2'b10;
    localparam logic [1:0] COND_OV     = 2'b11;

    localparam logic [2:0] ALU_AND = 3'b000;
    localparam logic [2:0] ALU_OR  = 3'b001;
    localparam logic [2:0] ALU_XOR = 3'b010;
    localparam logic [2:0] ALU_NOT = 3'b011;
    localparam logic [2:0] ALU_ADD = 3'b100;
    localparam logic [2:0] ALU_SUB = 3'b101;
    localparam logic [2:0] ALU_INC = 3'b110;
    localparam logic [2:0] ALU_DEC = 3'b111;

    localparam int FLAG_OV = 0;
    localparam int FLAG_Z  = 1;

    localparam int         FETCH_STATE_W = 2;
    localparam logic [1:0] FETCH_IDLE    = 2'd0;
    localparam logic [1:0] FETCH_OP      = 2'd1;
    localparam logic [1:0] FETCH_IMM     = 2'd2;

    // Same opcode byte seen as register form or jump form
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rd;
            logic [1:0] rs;
        } r;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rsvd;
            logic [1:0] cond;
        } j;
    } instr_u;

    function automatic logic [1:0] instr_size(input logic [3:0] opcode);
        if (opcode == OP_MOV_IMM || opcode == OP_JMP_GRP) begin
            return 2'd2;
        end
        return 2'd1;
    endfunction

endpackage

`default_nettype wire

// ==== logic/alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
    input  wire [2:0]               alu_code,
    input  wire [cpu_pkg::DATA_W-1:0] op_a,
    input  wire [cpu_pkg::DATA_W-1:0] op_b,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output logic [1:0]              flags_next
);

    logic [cpu_pkg::DATA_W:0] wide; // Extra bit holds carry or borrow

    always_comb begin
        case (alu_code)
            cpu_pkg::ALU_AND: wide = {1'b0, op_a & op_b};
            cpu_pkg::ALU_OR:  wide = {1'b0, op_a | op_b};
            cpu_pkg::ALU_XOR: wide = {1'b0, op_a ^ op_b};
            cpu_pkg::ALU_NOT: wide = {1'b0, ~op_a};
            cpu_pkg::ALU_ADD: wide = {1'b0, op_a} + {1'b0, op_b};
            cpu_pkg::ALU_SUB: wide = {1'b0, op_a} - {1'b0, op_b}; // Top bit is borrow
            cpu_pkg::ALU_INC: wide = {1'b0, op_a} + 1'b1;
            cpu_pkg::ALU_DEC: wide = {1'b0, op_a} - 1'b1;
            default:          wide = '0;
        endcase
    end

    assign result = wide[cpu_pkg::DATA_W-1:0];

    always_comb begin
        flags_next = '0;
        flags_next[cpu_pkg::FLAG_OV] = wide[cpu_pkg::DATA_W]; // Zero for logic ops
        flags_next[cpu_pkg::FLAG_Z]  = (result == '0);
    end

endmodule

`default_nettype wire

// ==== logic/instr_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_fetch (
    input  wire                        clk,
    input  wire                        sys_rst,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic [cpu_pkg::ADDR_W-1:0] wb_adr,
    input  wire  [cpu_pkg::DATA_W-1:0] wb_dat_i,
    input  wire                        wb_ack,
    input  wire                        full,
    output logic                       push,
    output cpu_pkg::instr_u            push_op,
    output logic [cpu_pkg::DATA_W-1:0] push_imm,
    input  wire                        redirect,
    input  wire  [cpu_pkg::ADDR_W-1:0] redirect_adr
);

    logic [cpu_pkg::FETCH_STATE_W-1:0] state;
    logic [cpu_pkg::ADDR_W-1:0]        pc;
    logic                              discard; // Bus cycle now on the wrong path
    logic                              op_take;
    logic                              imm_take;
    logic                              two_byte;

    assign two_byte = (cpu_pkg::instr_size(wb_dat_i[7:4]) == 2'd2);

    // Byte accepted only if no redirect is pending or arriving
    assign op_take  = (state == cpu_pkg::FETCH_OP) && wb_ack && !redirect && !discard;
    assign imm_take = (state == cpu_pkg::FETCH_IMM) && wb_cyc && wb_ack &&
                      !redirect && !discard;

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            state   <= cpu_pkg::FETCH_IDLE;
            pc      <= '0;
            wb_cyc  <= 1'b0;
            wb_stb  <= 1'b0;
            wb_adr  <= '0;
            discard <= 1'b0;
            push    <= 1'b0;
        end else begin
            push <= op_take && !two_byte || imm_take;
            if (redirect) begin
                pc <= redirect_adr;
            end
            case (state)
                cpu_pkg::FETCH_IDLE: begin
                    // Wait out a pending push so the queue never overflows
                    if (!redirect && !full && !push) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_adr <= pc;
                        state  <= cpu_pkg::FETCH_OP;
                    end
                end
                cpu_pkg::FETCH_OP: begin
                    if (redirect) begin
                        discard <= 1'b1;
                    end
                    if (wb_ack) begin
                        wb_cyc  <= 1'b0;
                        wb_stb  <= 1'b0;
                        discard <= 1'b0;
                        state   <= cpu_pkg::FETCH_IDLE;
                        if (op_take) begin
                            pc <= pc + 1'b1;
                            if (two_byte) begin
                                state <= cpu_pkg::FETCH_IMM;
                            end
                        end
                    end
                end
                cpu_pkg::FETCH_IMM: begin
                    if (!wb_cyc) begin
                        if (redirect) begin
                            state <= cpu_pkg::FETCH_IDLE; // Nothing on the bus yet
                        end else begin
                            wb_cyc <= 1'b1;
                            wb_stb <= 1'b1;
                            wb_adr <= pc;
                        end
                    end else begin
                        if (redirect) begin
                            discard <= 1'b1;
                        end
                        if (wb_ack) begin
                            wb_cyc  <= 1'b0;
                            wb_stb  <= 1'b0;
                            discard <= 1'b0;
                            state   <= cpu_pkg::FETCH_IDLE;
                            if (imm_take) begin
                                pc <= pc + 1'b1;
                            end
                        end
                    end
                end
                default: state <= cpu_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op_take) begin
            push_op <= wb_dat_i;
        end
        if (imm_take) begin
            push_imm <= wb_dat_i;
        end
    end

    // Slave acks only inside a strobed bus cycle
    assert property (@(posedge clk) disable iff (sys_rst) wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

// ==== logic/instr_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_queue (
    input  wire                        clk,
    input  wire                        sys_rst,
    input  wire                        push,
    input  wire  cpu_pkg::instr_u      push_op,
    input  wire  [cpu_pkg::DATA_W-1:0] push_imm,
    output logic                       full,
    input  wire                        pop,
    output logic                       empty,
    output cpu_pkg::instr_u            head_op,
    output logic [cpu_pkg::DATA_W-1:0] head_imm,
    input  wire                        flush
);

    cpu_pkg::instr_u             op_mem  [cpu_pkg::QUEUE_DEPTH];
    logic [cpu_pkg::DATA_W-1:0]  imm_mem [cpu_pkg::QUEUE_DEPTH];
    logic [cpu_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [cpu_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [cpu_pkg::QUEUE_CNT_W-1:0] count;
    logic                            wr_en;
    logic                            rd_en;

    assign full  = (count == cpu_pkg::QUEUE_CNT_W'(cpu_pkg::QUEUE_DEPTH));
    assign empty = (count == '0);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign head_op  = op_mem[rd_ptr];
    assign head_imm = imm_mem[rd_ptr];

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0; // Push in the same cycle is wrong path
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            op_mem[wr_ptr]  <= push_op;
            imm_mem[wr_ptr] <= push_imm;
        end
    end

    assert property (@(posedge clk) disable iff (sys_rst) !(push && full));
    assert property (@(posedge clk) disable iff (sys_rst) !(pop && empty));

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  wire                           clk,
    input  wire                           sys_rst,
    input  wire                           empty,
    input  wire  cpu_pkg::instr_u         head_op,
    input  wire  [cpu_pkg::DATA_W-1:0]    head_imm,
    output logic                          pop,
    output logic                          redirect,
    output logic [cpu_pkg::ADDR_W-1:0]    redirect_adr,
    output logic                          reg_wr_en,
    output logic [cpu_pkg::REG_SEL_W-1:0] reg_wr_addr,
    output logic [cpu_pkg::DATA_W-1:0]    reg_wr_data,
    output logic [1:0]                    flags
);

    logic [cpu_pkg::DATA_W-1:0]    regs [4];
    logic [cpu_pkg::REG_SEL_W-1:0] rd;
    logic [cpu_pkg::REG_SEL_W-1:0] rs;
    logic [1:0]                    cond;
    logic [cpu_pkg::DATA_W-1:0]    op_a;
    logic [cpu_pkg::DATA_W-1:0]    op_b;
    logic [2:0]                    alu_code;
    logic [cpu_pkg::DATA_W-1:0]    alu_result;
    logic [1:0]                    alu_flags;
    logic                          is_alu;
    logic                          is_write;
    logic                          is_jmp;
    logic                          taken;
    logic [cpu_pkg::DATA_W-1:0]    wr_val;

    // Hold off while the queue is being flushed by our own jump
    assign pop = !empty && !redirect;

    assign rd   = head_op.r.rd;
    assign rs   = head_op.r.rs;
    assign cond = head_op.j.cond;
    assign op_a = regs[rd];
    assign op_b = regs[rs];

    always_comb begin
        is_alu   = 1'b1;
        alu_code = cpu_pkg::ALU_AND;
        case (head_op.r.opcode)
            cpu_pkg::OP_AND: alu_code = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR:  alu_code = cpu_pkg::ALU_OR;
            cpu_pkg::OP_XOR: alu_code = cpu_pkg::ALU_XOR;
            cpu_pkg::OP_NOT: alu_code = cpu_pkg::ALU_NOT;
            cpu_pkg::OP_ADD: alu_code = cpu_pkg::ALU_ADD;
            cpu_pkg::OP_SUB: alu_code = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_INC: alu_code = cpu_pkg::ALU_INC;
            cpu_pkg::OP_DEC: alu_code = cpu_pkg::ALU_DEC;
            default:         is_alu   = 1'b0;
        endcase
    end

    always_comb begin
        is_write = 1'b1;
        case (head_op.r.opcode)
            cpu_pkg::OP_MOV_RR:  wr_val = op_b;
            cpu_pkg::OP_MOV_IMM: wr_val = head_imm;
            default: begin
                wr_val   = alu_result;
                is_write = is_alu; // Unused opcodes fall through as no-ops
            end
        endcase
    end

    assign is_jmp = (head_op.j.opcode == cpu_pkg::OP_JMP_GRP);

    always_comb begin
        case (cond)
            cpu_pkg::COND_ALWAYS: taken = is_jmp;
            cpu_pkg::COND_Z:      taken = is_jmp && flags[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_NZ:     taken = is_jmp && !flags[cpu_pkg::FLAG_Z];
            default:              taken = is_jmp && flags[cpu_pkg::FLAG_OV];
        endcase
    end

    alu_unit alu0 (
        .alu_code   (alu_code),
        .op_a       (op_a),
        .op_b       (op_b),
        .result     (alu_result),
        .flags_next (alu_flags)
    );

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            reg_wr_en <= 1'b0;
            redirect  <= 1'b0;
            flags     <= '0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            reg_wr_en <= pop && is_write;
            redirect  <= pop && taken;
            if (pop && is_write) begin
                regs[rd] <= wr_val;
            end
            if (pop && is_alu) begin
                flags <= alu_flags; // MOV leaves flags alone
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop && is_write) begin
            reg_wr_addr <= rd;
            reg_wr_data <= wr_val;
        end
        if (pop && taken) begin
            redirect_adr <= head_imm[cpu_pkg::ADDR_W-1:0];
        end
    end

    // Flush must land before the next instruction is taken
    assert property (@(posedge clk) disable iff (sys_rst) redirect |=> empty);

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
    input  wire                           clk,
    input  wire                           sys_rst,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic [cpu_pkg::ADDR_W-1:0]    wb_adr,
    input  wire  [cpu_pkg::DATA_W-1:0]    wb_dat_i,
    input  wire                           wb_ack,
    output logic                          reg_wr_en,
    output logic [cpu_pkg::REG_SEL_W-1:0] reg_wr_addr,
    output logic [cpu_pkg::DATA_W-1:0]    reg_wr_data,
    output logic [1:0]                    flags
);

    logic                       push;
    cpu_pkg::instr_u            push_op;
    logic [cpu_pkg::DATA_W-1:0] push_imm;
    logic                       full;
    logic                       pop;
    logic                       empty;
    cpu_pkg::instr_u            head_op;
    logic [cpu_pkg::DATA_W-1:0] head_imm;
    logic                       redirect;
    logic [cpu_pkg::ADDR_W-1:0] redirect_adr;

    instr_fetch fetch0 (
        .clk          (clk),
        .sys_rst      (sys_rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .full         (full),
        .push         (push),
        .push_op      (push_op),
        .push_imm     (push_imm),
        .redirect     (redirect),
        .redirect_adr (redirect_adr)
    );

    instr_queue queue0 (
        .clk      (clk),
        .sys_rst  (sys_rst),
        .push     (push),
        .push_op  (push_op),
        .push_imm (push_imm),
        .full     (full),
        .pop      (pop),
        .empty    (empty),
        .head_op  (head_op),
        .head_imm (head_imm),
        .flush    (redirect) // Taken jump drops everything fetched ahead
    );

    exec_unit exec0 (
        .clk          (clk),
        .sys_rst      (sys_rst),
        .empty        (empty),
        .head_op      (head_op),
        .head_imm     (head_imm),
        .pop          (pop),
        .redirect     (redirect),
        .redirect_adr (redirect_adr),
        .reg_wr_en    (reg_wr_en),
        .reg_wr_addr  (reg_wr_addr),
        .reg_wr_data  (reg_wr_data),
        .flags        (flags)
    );

endmodule

`default_nettype wire

// ==== verif/tb_cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core;

    logic       clk;
    logic       sys_rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic [7:0] wb_adr;
    logic [7:0] wb_dat_i;
    logic       wb_ack;
    logic       reg_wr_en;
    logic [1:0] reg_wr_addr;
    logic [7:0] reg_wr_data;
    logic [1:0] flags;

    logic [7:0]  mem [256];
    logic [15:0] lfsr;
    logic        slow_mem;  // Random wait states when set
    logic        bus_busy;
    int          wait_left;
    int          wp;        // Program write pointer

    logic [1:0] exp_addr [$];
    logic [7:0] exp_data [$];
    logic [1:0] exp_flags [$];
    logic [1:0] ea;
    logic [7:0] ed;
    logic [1:0] ef;

    int errors;
    int writes_seen;
    int test_writes;
    int test_err_base;
    int total_writes;
    int tests_run;
    string test_name;

    cpu_core dut0 (
        .clk         (clk),
        .sys_rst     (sys_rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .flags       (flags)
    );

    always #10 clk = ~clk;

    // Taps 16,14,13,11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    function automatic void expect_write(input logic [1:0] rd, input logic [7:0] val,
                                         input logic [1:0] fl);
        exp_addr.push_back(rd);
        exp_data.push_back(val);
        exp_flags.push_back(fl);
    endfunction

    // Interprets mem from address 0 until a taken jump to itself
    function automatic void build_expected();
        logic [7:0] r [4];
        logic [7:0] pc;
        logic [7:0] b;
        logic [7:0] imm;
        logic [7:0] a_v;
        logic [7:0] b_v;
        logic [7:0] res;
        logic [3:0] op;
        logic [1:0] rd;
        logic [1:0] rs;
        logic       z;
        logic       ov;
        logic       tk;
        logic       done;
        int         steps;
        for (int i = 0; i < 4; i++) begin
            r[i] = 8'h00;
        end
        pc = 8'h00;
        z = 1'b0;
        ov = 1'b0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            b = mem[pc];
            imm = mem[pc + 8'd1];
            op = b[7:4];
            rd = b[3:2];
            rs = b[1:0];
            steps++;
            if (op == cpu_pkg::OP_MOV_RR || op == cpu_pkg::OP_MOV_IMM) begin
                r[rd] = (op == cpu_pkg::OP_MOV_RR) ? r[rs] : imm;
                expect_write(rd, r[rd], {z, ov});
                pc = pc + ((op == cpu_pkg::OP_MOV_RR) ? 8'd1 : 8'd2);
            end else if (op == cpu_pkg::OP_JMP_GRP) begin
                case (rs)
                    cpu_pkg::COND_ALWAYS: tk = 1'b1;
                    cpu_pkg::COND_Z:      tk = z;
                    cpu_pkg::COND_NZ:     tk = !z;
                    default:              tk = ov;
                endcase
                done = tk && (imm == pc);
                pc = tk ? imm : pc + 8'd2;
            end else if (op[3]) begin
                a_v = r[rd];
                b_v = r[rs];
                ov = 1'b0;
                case (op)
                    cpu_pkg::OP_AND: res = a_v & b_v;
                    cpu_pkg::OP_OR:  res = a_v | b_v;
                    cpu_pkg::OP_XOR: res = a_v ^ b_v;
                    cpu_pkg::OP_NOT: res = ~a_v;
                    cpu_pkg::OP_ADD: begin
                        res = a_v + b_v;
                        ov = (res < a_v); // Wrapped sum means carry out
                    end
                    cpu_pkg::OP_SUB: begin
                        res = a_v - b_v;
                        ov = (a_v < b_v);
                    end
                    cpu_pkg::OP_INC: begin
                        res = a_v + 8'd1;
                        ov = (a_v == 8'hFF);
                    end
                    default: begin
                        res = a_v - 8'd1;
                        ov = (a_v == 8'h00);
                    end
                endcase
                z = (res == 8'h00);
                r[rd] = res;
                expect_write(rd, res, {z, ov});
                pc = pc + 8'd1;
            end else begin
                pc = pc + 8'd1; // Unused opcode
            end
        end
    endfunction

    // Program memory, Wishbone classic slave
    always @(negedge clk) begin
        if (sys_rst || wb_ack) begin
            wb_ack <= 1'b0;
            bus_busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                wait_left = slow_mem ? rand_bits(2) : 0;
            end
            if (wait_left == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_i <= mem[wb_adr];
            end else begin
                wait_left--;
            end
        end
    end

    // Compares each register write against the next expected one
    always @(negedge clk) begin
        if (!sys_rst && reg_wr_en) begin
            assert (exp_addr.size() > 0) else begin
                $display("Unexpected register write to R%0d with %02h at %0t",
                         reg_wr_addr, reg_wr_data, $time);
                errors++;
            end
            if (exp_addr.size() > 0) begin
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                ef = exp_flags.pop_front();
                assert (reg_wr_addr == ea && reg_wr_data == ed && flags == ef) else begin
                    $display("Error at %0t: got R%0d=%02h fl %02b, exp R%0d=%02h fl %02b",
                             $time, reg_wr_addr, reg_wr_data, flags, ea, ed, ef);
                    errors++;
                end
            end
            writes_seen++;
        end
    end

    task automatic put_byte(input logic [7:0] b);
        mem[wp[7:0]] = b;
        wp++;
    endtask

    task automatic mov_imm(input logic [1:0] rd, input logic [7:0] val);
        put_byte({cpu_pkg::OP_MOV_IMM, rd, 2'b00});
        put_byte(val);
    endtask

    task automatic alu_op(input logic [3:0] op, input logic [1:0] rd, input logic [1:0] rs);
        put_byte({op, rd, rs});
    endtask

    task automatic jump_to(input logic [1:0] cond, input logic [7:0] target);
        put_byte({cpu_pkg::OP_JMP_GRP, 2'b00, cond});
        put_byte(target);
    endtask

    task automatic halt_loop();
        jump_to(cpu_pkg::COND_ALWAYS, 8'(wp));
    endtask

    // Jump over one MOV immediate into B
    task automatic skip_mov(input logic [1:0] cond, input logic [7:0] val);
        jump_to(cond, 8'(wp + 4));
        mov_imm(2'd1, val);
    endtask

    task automatic start_test(input string name, input logic slow);
        @(negedge clk);
        sys_rst <= 1'b1;
        slow_mem = slow;
        test_name = name;
        test_err_base = errors;
        test_writes = 0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(a) ^ 8'hA5;
        end
        wp = 0;
    endtask

    task automatic run_program();
        int timer;
        int n;
        exp_addr.delete();
        exp_data.delete();
        exp_flags.delete();
        build_expected();
        n = exp_addr.size();
        writes_seen = 0;
        timer = 0;
        repeat (16) @(negedge clk);
        sys_rst <= 1'b0;
        while (writes_seen < n && timer < 20000) begin
            @(negedge clk);
            timer++;
        end
        assert (writes_seen >= n) else begin
            $display("Timeout: register write %0d of %0d never arrived", writes_seen + 1, n);
            errors++;
        end
        repeat (50) @(negedge clk); // Window for stray writes
        test_writes += writes_seen;
        total_writes += writes_seen;
        sys_rst <= 1'b1;
    endtask

    task automatic end_test();
        tests_run++;
        $display("Test %0d %s: %0d writes checked, %0d errors",
                 tests_run, test_name, test_writes, errors - test_err_base);
    endtask

    task automatic make_random_program();
        int starts [$];
        int jat [$];
        int jins [$];
        int kind;
        int idx;
        logic [1:0] rd;
        logic [1:0] rs;
        while (wp < 240) begin
            starts.push_back(wp);
            kind = rand_bits(3);
            rd = 2'(rand_bits(2));
            rs = 2'(rand_bits(2));
            case (kind)
                0, 1: mov_imm(rd, 8'(rand_bits(8)));
                2: begin
                    jins.push_back(starts.size() - 1);
                    jat.push_back(wp + 1);
                    jump_to(rs, 8'h00); // Target patched below
                end
                3: alu_op(cpu_pkg::OP_MOV_RR, rd, rs);
                default: alu_op({1'b1, 3'(rand_bits(3))}, rd, rs);
            endcase
        end
        while (wp < 250) begin
            put_byte(8'h20);
        end
        halt_loop();
        // Forward only, onto an instruction start or the final loop
        for (int i = 0; i < jat.size(); i++) begin
            idx = jins[i] + 1 + rand_bits(2);
            mem[jat[i]] = (idx < starts.size()) ? 8'(starts[idx]) : 8'd250;
        end
    endtask

    initial begin
        clk = 1'b0;
        sys_rst = 1'b1;
        wb_ack = 1'b0;
        wb_dat_i = 8'h00;
        lfsr = 16'd15;
        slow_mem = 1'b0;
        bus_busy = 1'b0;
        wait_left = 0;
        errors = 0;
        total_writes = 0;
        tests_run = 0;

        start_test("mov", 1'b0);
        mov_imm(2'd0, 8'h3C);
        mov_imm(2'd1, 8'hC3);
        mov_imm(2'd2, 8'h5A);
        mov_imm(2'd3, 8'h00);
        alu_op(cpu_pkg::OP_MOV_RR, 2'd0, 2'd1);
        alu_op(cpu_pkg::OP_MOV_RR, 2'd3, 2'd2);
        alu_op(cpu_pkg::OP_MOV_RR, 2'd2, 2'd0);
        alu_op(cpu_pkg::OP_MOV_RR, 2'd1, 2'd3);
        halt_loop();
        run_program();
        end_test();

        start_test("alu", 1'b1);
        mov_imm(2'd0, 8'hF0);
        mov_imm(2'd1, 8'h3C);
        mov_imm(2'd2, 8'hC8);
        mov_imm(2'd3, 8'h64);
        alu_op(cpu_pkg::OP_AND, 2'd0, 2'd1);
        alu_op(cpu_pkg::OP_OR, 2'd0, 2'd1);
        alu_op(cpu_pkg::OP_XOR, 2'd1, 2'd0);
        alu_op(cpu_pkg::OP_NOT, 2'd1, 2'd0);
        alu_op(cpu_pkg::OP_ADD, 2'd2, 2'd3); // 200 + 100 wraps
        alu_op(cpu_pkg::OP_SUB, 2'd3, 2'd2);
        alu_op(cpu_pkg::OP_SUB, 2'd2, 2'd3); // Borrow
        mov_imm(2'd0, 8'hFF);
        alu_op(cpu_pkg::OP_INC, 2'd0, 2'd0);
        alu_op(cpu_pkg::OP_DEC, 2'd0, 2'd0);
        alu_op(cpu_pkg::OP_XOR, 2'd3, 2'd3);
        halt_loop();
        run_program();
        end_test();

        start_test("jumps", 1'b0);
        mov_imm(2'd0, 8'h01);
        skip_mov(cpu_pkg::COND_ALWAYS, 8'hEE);
        alu_op(cpu_pkg::OP_XOR, 2'd2, 2'd2); // Z set, OV clear
        skip_mov(cpu_pkg::COND_Z, 8'hE1);
        skip_mov(cpu_pkg::COND_NZ, 8'h12);
        skip_mov(cpu_pkg::COND_OV, 8'h13);
        alu_op(cpu_pkg::OP_DEC, 2'd2, 2'd0); // Borrow, Z clear
        skip_mov(cpu_pkg::COND_OV, 8'hE2);
        skip_mov(cpu_pkg::COND_NZ, 8'hE3);
        skip_mov(cpu_pkg::COND_Z, 8'h14);
        mov_imm(2'd3, 8'h77);
        halt_loop();
        run_program();
        end_test();

        start_test("backpressure", 1'b1);
        mov_imm(2'd0, 8'h01);
        mov_imm(2'd1, 8'h03);
        for (int i = 0; i < 48; i++) begin
            alu_op((i % 3 == 0) ? cpu_pkg::OP_MOV_RR :
                   (i % 3 == 1) ? cpu_pkg::OP_ADD : cpu_pkg::OP_DEC, 2'(i), 2'(i + 1));
        end
        halt_loop();
        run_program();
        end_test();

        start_test("random", 1'b1);
        for (int p = 0; p < 10 && test_writes < 200; p++) begin
            if (p > 0) begin
                @(negedge clk); // Bus model idles in reset first
                for (int a = 0; a < 256; a++) begin
                    mem[a] = 8'(a) ^ 8'hA5;
                end
                wp = 0;
            end
            make_random_program();
            run_program();
        end
        end_test();

        start_test("unused", 1'b1);
        mov_imm(2'd0, 8'h05);
        put_byte(8'h2C);
        alu_op(cpu_pkg::OP_INC, 2'd0, 2'd0);
        put_byte(8'h3F);
        put_byte(8'h41);
        put_byte(8'h6A);
        put_byte(8'h77);
        alu_op(cpu_pkg::OP_MOV_RR, 2'd1, 2'd0);
        halt_loop();
        run_program();
        end_test();

        $display("Summary: %0d tests, %0d register writes checked, %0d errors",
                 tests_run, total_writes, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/cpu_pkg.sv
logic/alu_unit.sv
logic/instr_fetch.sv
logic/instr_queue.sv
logic/exec_unit.sv
logic/cpu_core.sv
verif/tb_cpu_core.sv
